// ==== separate_caches.f ====
+incdir+.
cache_pkg.sv
direct_mapped_cache.sv
mem_arbiter.sv
separate_caches.sv
tb_separate_caches.sv

// ==== Makefile ====
# Verilator build and run of the split L1 cache testbench
VERILATOR ?= verilator
TOP       ?= tb_separate_caches
FILELIST  ?= separate_caches.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST PASS

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_separate_caches.sv ====
/* testbench for the split L1 caches with a random-latency memory and a reference model
   data and instruction pipelines run concurrently from a seeded LFSR */
`timescale 1ns/10ps

module tb_separate_caches;

    localparam int          DATA_OPS    = 240;
    localparam int          INSTR_OPS   = 240;
    localparam int          TOTAL_OPS   = 2 * (DATA_OPS + INSTR_OPS);
    localparam int          WATCHDOG_NS = (TOTAL_OPS * 40 + 2000) * 40;
    localparam int          EXPECT_ANY  = 0;
    localparam int          EXPECT_HIT  = 1;
    localparam int          EXPECT_MISS = 2;
    localparam logic [31:0] LFSR_SEED   = 32'h7c4e_8f80;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

    logic                CLK;
    logic                rst;
    cache_pkg::bus_req_t icache_req;
    cache_pkg::bus_req_t dcache_req;
    cache_pkg::bus_rsp_t icache_rsp;
    cache_pkg::bus_rsp_t dcache_rsp;
    cache_pkg::bus_req_t mem_req;
    cache_pkg::bus_rsp_t mem_rsp;
    logic                iflush;
    logic                iclear;
    logic                dflush;
    logic                dclear;
    logic                iflush_done;
    logic                iclear_done;
    logic                dflush_done;
    logic                dclear_done;
    logic                icache_miss;
    logic                dcache_miss;

    // words 0..63 are data, words 64..127 hold instructions
    cache_pkg::word_t mem [128];
    cache_pkg::word_t ref_mem [64];
    logic [31:0]      data_lfsr;
    logic [31:0]      instr_lfsr;
    logic [31:0]      mem_lfsr;
    logic [31:0]      mem_draw;
    bit               mem_xfer;
    int               mem_wait;
    int               errors;
    int               checks;

    separate_caches u_dut (.*);

    always #20 CLK = ~CLK;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], state[0]};
            state = lfsr_step(state);
        end
    endtask

    function automatic cache_pkg::word_t fill_word(input logic [6:0] idx);
        return ({25'd0, idx} * 32'h9e37_79b1) ^ {idx, ~idx, idx, 11'h5a3};
    endfunction

    // memory behind the arbiter, 0 to 3 wait cycles per transfer
    always begin
        @(posedge CLK);
        #2;
        mem_rsp = '0;
        if (mem_req.ren || mem_req.wen) begin
            if (mem_req.addr[31:9] != '0) begin
                errors++;
                $display("memory request at %h is outside the modeled window", mem_req.addr);
            end
            if (!mem_xfer) begin
                draw_bits(mem_lfsr, 2, mem_draw);
                mem_wait = int'(mem_draw);
                mem_xfer = 1'b1;
            end else begin
                mem_wait--;
            end
            mem_rsp.busy = (mem_wait != 0);
            if (mem_wait == 0) begin
                // transfer completes at the next edge
                mem_xfer = 1'b0;
                if (mem_req.ren) begin
                    mem_rsp.rdata = mem[mem_req.addr[8:2]];
                end
                for (int b = 0; b < 4; b++) begin
                    if (mem_req.wen && mem_req.byte_en[b]) begin
                        mem[mem_req.addr[8:2]][8*b +: 8] = mem_req.wdata[8*b +: 8];
                    end
                end
            end
        end else begin
            mem_xfer = 1'b0;
        end
    end

    task automatic cache_read(input bit instr, input logic [5:0] w, input int expect_kind);
        cache_pkg::bus_req_t req;
        cache_pkg::bus_rsp_t rsp;
        cache_pkg::word_t    expected;
        bit                  missed;
        int                  waits;
        req         = '0;
        req.addr    = instr ? {23'd0, 1'b1, w, 2'b00} : {24'd0, w, 2'b00};
        req.ren     = 1'b1;
        req.byte_en = '1;
        expected    = instr ? fill_word({1'b1, w}) : ref_mem[w];
        if (instr) icache_req = req;
        else dcache_req = req;
        missed = 1'b0;
        waits  = 0;
        do begin
            @(negedge CLK);
            rsp = instr ? icache_rsp : dcache_rsp;
            if (instr ? icache_miss : dcache_miss) missed = 1'b1;
            if (rsp.busy) waits++;
        end while (rsp.busy);
        checks++;
        if (rsp.rdata !== expected) begin
            errors++;
            $display("error: %s.rdata at %h expected %h got %h",
                     instr ? "icache_rsp" : "dcache_rsp", req.addr, expected, rsp.rdata);
        end
        if (expect_kind == EXPECT_HIT && (waits != 0 || missed)) begin
            errors++;
            $display("repeated read at %h did not complete as a hit", req.addr);
        end
        if (expect_kind == EXPECT_MISS && !missed) begin
            errors++;
            $display("first read at %h after flush or clear raised no miss flag", req.addr);
        end
        @(posedge CLK);
        #2;
        if (instr) icache_req = '0;
        else dcache_req = '0;
    endtask

    task automatic data_write(input logic [5:0] w, input cache_pkg::word_t d,
                              input cache_pkg::byte_en_t be);
        dcache_req         = '0;
        dcache_req.addr    = {24'd0, w, 2'b00};
        dcache_req.wdata   = d;
        dcache_req.wen     = 1'b1;
        dcache_req.byte_en = be;
        do begin
            @(negedge CLK);
        end while (dcache_rsp.busy);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) ref_mem[w][8*b +: 8] = d[8*b +: 8];
        end
        @(posedge CLK);
        #2;
        dcache_req = '0;
    endtask

    // hold the flush or clear level until its done pulse
    task automatic cache_control(input bit instr, input bit do_flush);
        bit flush_seen;
        bit clear_seen;
        if (instr) begin
            iflush = do_flush;
            iclear = !do_flush;
        end else begin
            dflush = do_flush;
            dclear = !do_flush;
        end
        do begin
            @(negedge CLK);
            flush_seen = instr ? iflush_done : dflush_done;
            clear_seen = instr ? iclear_done : dclear_done;
        end while (!(flush_seen || clear_seen));
        checks++;
        if (flush_seen != do_flush || clear_seen == do_flush) begin
            errors++;
            $display("%s cache answered with the wrong done pulse", instr ? "instruction" : "data");
        end
        @(posedge CLK);
        #2;
        iflush = instr ? 1'b0 : iflush;
        iclear = instr ? 1'b0 : iclear;
        dflush = instr ? dflush : 1'b0;
        dclear = instr ? dclear : 1'b0;
    endtask

    task automatic compare_memory();
        for (int i = 0; i < 64; i++) begin
            checks++;
            if (mem[i] !== ref_mem[i]) begin
                errors++;
                $display("error: mem[%0d] expected %h got %h", i, ref_mem[i], mem[i]);
            end
        end
    endtask

    task automatic data_side();
        logic [31:0] r;
        logic [31:0] d;
        logic [5:0]  w;
        logic [5:0]  last_w;
        last_w = '0;
        for (int n = 0; n < DATA_OPS; n++) begin
            // flush then clear, each followed by a forced miss
            if (n % 80 == 79) begin
                cache_control(1'b0, 1'b1);
                compare_memory();
                cache_read(1'b0, last_w, EXPECT_MISS);
                cache_control(1'b0, 1'b0);
                cache_read(1'b0, last_w, EXPECT_MISS);
            end
            draw_bits(data_lfsr, 6, r);
            w = r[5:0];
            draw_bits(data_lfsr, 1, r);
            if (r[0]) begin
                draw_bits(data_lfsr, 32, d);
                draw_bits(data_lfsr, 4, r);
                data_write(w, d, r[3:0]);
            end else begin
                cache_read(1'b0, w, EXPECT_ANY);
                draw_bits(data_lfsr, 1, r);
                if (r[0]) cache_read(1'b0, w, EXPECT_HIT);
            end
            last_w = w;
        end
        cache_control(1'b0, 1'b1);
        compare_memory();
    endtask

    task automatic instr_side();
        logic [31:0] r;
        logic [5:0]  w;
        logic [5:0]  last_w;
        last_w = '0;
        for (int n = 0; n < INSTR_OPS; n++) begin
            if (n % 60 == 59) begin
                cache_control(1'b1, 1'b1);
                cache_read(1'b1, last_w, EXPECT_MISS);
                cache_control(1'b1, 1'b0);
                cache_read(1'b1, last_w, EXPECT_MISS);
            end
            draw_bits(instr_lfsr, 6, r);
            w = r[5:0];
            cache_read(1'b1, w, EXPECT_ANY);
            draw_bits(instr_lfsr, 1, r);
            if (r[0]) cache_read(1'b1, w, EXPECT_HIT);
            last_w = w;
        end
    endtask

    initial begin
        CLK        = 1'b0;
        rst        = 1'b1;
        icache_req = '0;
        dcache_req = '0;
        mem_rsp    = '0;
        iflush     = 1'b0;
        iclear     = 1'b0;
        dflush     = 1'b0;
        dclear     = 1'b0;
        mem_xfer   = 1'b0;
        mem_wait   = 0;
        errors     = 0;
        checks     = 0;
        for (int i = 0; i < 128; i++) mem[i] = fill_word(7'(i));
        for (int i = 0; i < 64; i++) ref_mem[i] = mem[i];
        // one seed, streams offset so they do not repeat each other
        data_lfsr  = LFSR_SEED;
        instr_lfsr = LFSR_SEED;
        mem_lfsr   = LFSR_SEED;
        for (int i = 0; i < 97; i++) instr_lfsr = lfsr_step(instr_lfsr);
        for (int i = 0; i < 211; i++) mem_lfsr = lfsr_step(mem_lfsr);
        repeat (16) @(posedge CLK);
        #2;
        rst = 1'b0;
        fork
            data_side();
            instr_side();
        join
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with requests still outstanding", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== separate_caches.sv ====
/* split L1 cache subsystem, instruction and data caches sharing one memory port
   pipeline drives the cache ports, memory sits behind the arbiter */
`timescale 1ns/10ps

module separate_caches (
    input  logic                CLK,
    input  logic                rst,
    input  cache_pkg::bus_req_t icache_req,
    input  cache_pkg::bus_req_t dcache_req,
    output cache_pkg::bus_rsp_t icache_rsp,
    output cache_pkg::bus_rsp_t dcache_rsp,
    output cache_pkg::bus_req_t mem_req,
    input  cache_pkg::bus_rsp_t mem_rsp,
    input  logic                iflush,
    input  logic                iclear,
    input  logic                dflush,
    input  logic                dclear,
    output logic                iflush_done,
    output logic                iclear_done,
    output logic                dflush_done,
    output logic                dclear_done,
    output logic                icache_miss,
    output logic                dcache_miss
);

    // miss traffic between each cache and the arbiter
    cache_pkg::bus_req_t icache_mem_req;
    cache_pkg::bus_rsp_t icache_mem_rsp;
    cache_pkg::bus_req_t dcache_mem_req;
    cache_pkg::bus_rsp_t dcache_mem_rsp;

    // read-only instruction side
    direct_mapped_cache #(
        .WRITABLE(1'b0)
    ) u_icache (
        .CLK(CLK),
        .rst(rst),
        .proc_req(icache_req),
        .proc_rsp(icache_rsp),
        .mem_req(icache_mem_req),
        .mem_rsp(icache_mem_rsp),
        .flush(iflush),
        .clear(iclear),
        .flush_done(iflush_done),
        .clear_done(iclear_done),
        .cache_miss(icache_miss)
    );

    direct_mapped_cache #(
        .WRITABLE(1'b1)
    ) u_dcache (
        .CLK(CLK),
        .rst(rst),
        .proc_req(dcache_req),
        .proc_rsp(dcache_rsp),
        .mem_req(dcache_mem_req),
        .mem_rsp(dcache_mem_rsp),
        .flush(dflush),
        .clear(dclear),
        .flush_done(dflush_done),
        .clear_done(dclear_done),
        .cache_miss(dcache_miss)
    );

    mem_arbiter u_arbiter (
        .CLK(CLK),
        .rst(rst),
        .icache_req(icache_mem_req),
        .dcache_req(dcache_mem_req),
        .icache_rsp(icache_mem_rsp),
        .dcache_rsp(dcache_mem_rsp),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

endmodule

// ==== mem_arbiter.sv ====
/* shares one memory port between the instruction and data cache miss paths
   data cache wins ties and the grant is held until memory drops busy */
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                CLK,
    input  logic                rst,
    input  cache_pkg::bus_req_t icache_req,
    input  cache_pkg::bus_req_t dcache_req,
    output cache_pkg::bus_rsp_t icache_rsp,
    output cache_pkg::bus_rsp_t dcache_rsp,
    output cache_pkg::bus_req_t mem_req,
    input  cache_pkg::bus_rsp_t mem_rsp
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_ICACHE,
        OWN_DCACHE
    } owner_t;

    owner_t owner;
    owner_t grant;
    logic   ireq_valid;
    logic   dreq_valid;
    logic   grant_i;
    logic   grant_d;

    assign ireq_valid = icache_req.ren || icache_req.wen;
    assign dreq_valid = dcache_req.ren || dcache_req.wen;

    // a locked owner keeps the grant before data cache priority applies
    always_comb begin
        if (owner != OWN_NONE) begin
            grant = owner;
        end else if (dreq_valid) begin
            grant = OWN_DCACHE;
        end else if (ireq_valid) begin
            grant = OWN_ICACHE;
        end else begin
            grant = OWN_NONE;
        end
    end

    assign grant_i = (grant == OWN_ICACHE);
    assign grant_d = (grant == OWN_DCACHE);

    always_comb begin
        mem_req          = '0;
        icache_rsp.rdata = '0;
        icache_rsp.busy  = ireq_valid;
        dcache_rsp.rdata = '0;
        dcache_rsp.busy  = dreq_valid;
        if (grant_d) begin
            mem_req    = dcache_req;
            dcache_rsp = mem_rsp;
        end else if (grant_i) begin
            mem_req    = icache_req;
            icache_rsp = mem_rsp;
        end
    end

    // lock only when the transfer spans more than one cycle
    always_ff @(posedge CLK) begin
        if (rst) begin
            owner <= OWN_NONE;
        end else if (owner == OWN_NONE) begin
            if ((grant != OWN_NONE) && mem_rsp.busy) begin
                owner <= grant;
            end
        end else if (!mem_rsp.busy) begin
            owner <= OWN_NONE;
        end
    end

    // a transfer in progress never hands the port to the other cache
    a_single_grant: assert property (@(posedge CLK) disable iff (rst)
        (grant != OWN_NONE) && mem_rsp.busy |=> grant == $past(grant))
        else $error("memory port grant moved to the other cache during a transfer");

endmodule

// ==== direct_mapped_cache.sv ====
/* direct mapped write-back L1 cache, one word per line, with flush and clear
   WRITABLE=1 gives the data cache, WRITABLE=0 the read-only instruction cache */
`timescale 1ns/10ps
`include "cache_defs.svh"

module direct_mapped_cache #(
    parameter bit WRITABLE = 1'b1
) (
    input  logic                CLK,
    input  logic                rst,
    input  cache_pkg::bus_req_t proc_req,
    output cache_pkg::bus_rsp_t proc_rsp,
    output cache_pkg::bus_req_t mem_req,
    input  cache_pkg::bus_rsp_t mem_rsp,
    input  logic                flush,
    input  logic                clear,
    output logic                flush_done,
    output logic                clear_done,
    output logic                cache_miss
);

    localparam cache_pkg::index_t LAST_SET = cache_pkg::index_t'(`CACHE_SETS - 1);

    cache_pkg::cache_line_t  lines [`CACHE_SETS];
    cache_pkg::cache_state_t state;
    cache_pkg::cache_state_t next_state;
    cache_pkg::index_t       req_idx;
    cache_pkg::tag_t         req_tag;
    cache_pkg::index_t       flush_idx;
    cache_pkg::cache_line_t  req_line;
    cache_pkg::cache_line_t  flush_line;
    cache_pkg::word_t        merged;
    logic                    flush_op;
    logic                    req_valid;
    logic                    hit;

    // address splits into tag, index and byte offset
    assign req_idx   = proc_req.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign req_tag   = proc_req.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign req_valid = proc_req.ren || proc_req.wen;

    assign req_line   = lines[req_idx];
    assign flush_line = lines[flush_idx];
    assign hit        = req_line.valid && (req_line.tag == req_tag);

    // store data merged into the resident word
    always_comb begin
        merged = req_line.data;
        for (int b = 0; b < `CACHE_BE_W; b++) begin
            if (proc_req.byte_en[b]) begin
                merged[8*b +: 8] = proc_req.wdata[8*b +: 8];
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cache_pkg::IDLE: begin
                if (clear) begin
                    next_state = cache_pkg::DONE;
                end else if (flush) begin
                    next_state = cache_pkg::FLUSH_SCAN;
                end else if (req_valid && !hit) begin
                    // dirty victim goes out before the fill
                    if (req_line.valid && req_line.dirty) begin
                        next_state = cache_pkg::WRITEBACK;
                    end else begin
                        next_state = cache_pkg::FILL;
                    end
                end
            end
            cache_pkg::WRITEBACK: begin
                if (!mem_rsp.busy) begin
                    next_state = cache_pkg::FILL;
                end
            end
            cache_pkg::FILL: begin
                // request is served as a hit on return to idle
                if (!mem_rsp.busy) begin
                    next_state = cache_pkg::IDLE;
                end
            end
            cache_pkg::FLUSH_SCAN: begin
                if (flush_line.valid && flush_line.dirty) begin
                    next_state = cache_pkg::FLUSH_WB;
                end else if (flush_idx == LAST_SET) begin
                    next_state = cache_pkg::DONE;
                end
            end
            cache_pkg::FLUSH_WB: begin
                if (!mem_rsp.busy) begin
                    if (flush_idx == LAST_SET) begin
                        next_state = cache_pkg::DONE;
                    end else begin
                        next_state = cache_pkg::FLUSH_SCAN;
                    end
                end
            end
            default: begin
                next_state = cache_pkg::IDLE;
            end
        endcase
    end

    // memory side request
    always_comb begin
        mem_req = '0;
        case (state)
            cache_pkg::WRITEBACK: begin
                mem_req.addr    = {req_line.tag, req_idx, {`CACHE_OFFSET_W{1'b0}}};
                mem_req.wdata   = req_line.data;
                mem_req.wen     = 1'b1;
                mem_req.byte_en = '1;
            end
            cache_pkg::FILL: begin
                mem_req.addr    = {req_tag, req_idx, {`CACHE_OFFSET_W{1'b0}}};
                mem_req.ren     = 1'b1;
                mem_req.byte_en = '1;
            end
            cache_pkg::FLUSH_WB: begin
                mem_req.addr    = {flush_line.tag, flush_idx, {`CACHE_OFFSET_W{1'b0}}};
                mem_req.wdata   = flush_line.data;
                mem_req.wen     = 1'b1;
                mem_req.byte_en = '1;
            end
            default: begin
                mem_req = '0;
            end
        endcase
    end

    // hits answer in the request cycle
    assign proc_rsp.rdata = req_line.data;
    assign proc_rsp.busy  = req_valid && !((state == cache_pkg::IDLE) && hit);

    assign cache_miss = ((state == cache_pkg::IDLE) && req_valid && !hit)
                     || (state == cache_pkg::WRITEBACK)
                     || (state == cache_pkg::FILL);

    assign flush_done = (state == cache_pkg::DONE) && flush_op;
    assign clear_done = (state == cache_pkg::DONE) && !flush_op;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state     <= cache_pkg::IDLE;
            flush_idx <= '0;
            flush_op  <= 1'b0;
            for (int i = 0; i < `CACHE_SETS; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
            end
        end else begin
            state <= next_state;
            case (state)
                cache_pkg::IDLE: begin
                    if (clear) begin
                        flush_op <= 1'b0;
                        for (int i = 0; i < `CACHE_SETS; i++) begin
                            lines[i].valid <= 1'b0;
                            lines[i].dirty <= 1'b0;
                        end
                    end else if (flush) begin
                        flush_op  <= 1'b1;
                        flush_idx <= '0;
                    end else if (WRITABLE && proc_req.wen && hit) begin
                        lines[req_idx].data  <= merged;
                        lines[req_idx].dirty <= 1'b1;
                    end
                end
                cache_pkg::FILL: begin
                    if (!mem_rsp.busy) begin
                        lines[req_idx].valid <= 1'b1;
                        lines[req_idx].dirty <= 1'b0;
                        lines[req_idx].tag   <= req_tag;
                        lines[req_idx].data  <= mem_rsp.rdata;
                    end
                end
                cache_pkg::FLUSH_SCAN: begin
                    // clean or empty set is dropped and the walk moves on
                    if (!(flush_line.valid && flush_line.dirty)) begin
                        lines[flush_idx].valid <= 1'b0;
                        flush_idx              <= flush_idx + 1'b1;
                    end
                end
                cache_pkg::FLUSH_WB: begin
                    if (!mem_rsp.busy) begin
                        lines[flush_idx].valid <= 1'b0;
                        lines[flush_idx].dirty <= 1'b0;
                        flush_idx              <= flush_idx + 1'b1;
                    end
                end
                default: begin
                    flush_idx <= flush_idx;
                end
            endcase
        end
    end

    a_no_write_readonly: assert property (@(posedge CLK) disable iff (rst)
        (WRITABLE != 1'b0) || !proc_req.wen)
        else $error("write request on read-only cache");

    // memory transfer keeps its address and data until busy drops
    a_mem_req_stable: assert property (@(posedge CLK) disable iff (rst)
        (mem_req.ren || mem_req.wen) && mem_rsp.busy |=> $stable(mem_req))
        else $error("memory request changed while busy");

    // requester must hold its request until it completes
    a_req_stable: assert property (@(posedge CLK) disable iff (rst)
        req_valid && proc_rsp.busy |=> $stable(proc_req))
        else $error("processor request changed while busy");

endmodule

// ==== cache_pkg.sv ====
/* shared types for the split L1 caches and their memory arbiter
   referenced by scoped names from each module */
`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`CACHE_DATA_W-1:0]  word_t;
    typedef logic [`CACHE_ADDR_W-1:0]  addr_t;
    typedef logic [`CACHE_TAG_W-1:0]   tag_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;
    typedef logic [`CACHE_BE_W-1:0]    byte_en_t;

    // request side of the generic bus, processor or memory
    typedef struct packed {
        addr_t    addr;
        word_t    wdata;
        logic     ren;
        logic     wen;
        byte_en_t byte_en;
    } bus_req_t;

    // busy stays high until the transfer completes
    typedef struct packed {
        word_t rdata;
        logic  busy;
    } bus_rsp_t;

    typedef struct packed {
        logic  valid;
        logic  dirty;
        tag_t  tag;
        word_t data;
    } cache_line_t;

    typedef enum logic [2:0] {
        IDLE,
        WRITEBACK,
        FILL,
        FLUSH_SCAN,
        FLUSH_WB,
        DONE
    } cache_state_t;

endpackage

// ==== cache_defs.svh ====
/* address, data and set geometry shared by the cache subsystem
   include wherever the widths or the set count are needed */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// bus widths
`define CACHE_ADDR_W 32
`define CACHE_DATA_W 32

// one byte enable per data byte
`define CACHE_BE_W (`CACHE_DATA_W / 8)

// byte offset bits dropped from word addresses
`define CACHE_OFFSET_W 2

// direct mapped, one word per line
`define CACHE_SETS 16
`define CACHE_INDEX_W 4

// tag is what remains above index and offset
`define CACHE_TAG_W 26

`endif
